/* eth_dma_consts.svh */
// Widths and frame constants for the Ethernet transmit DMA
`ifndef ETH_DMA_CONSTS_SVH
`define ETH_DMA_CONSTS_SVH

// External memory bus
`define ETH_AXI_ADDR_W 32
`define ETH_AXI_DATA_W 32
`define ETH_AXI_LEN_W 8

// Frame buffer and descriptor table
`define ETH_BUF_ADDR_W 11
`define ETH_BD_ADDR_W 8

// Preamble and start-of-frame delimiter
`define ETH_PREAMBLE_LEN 7
`define ETH_PREAMBLE_BYTE 8'h55
`define ETH_SFD_BYTE 8'hD5

// Beats per read burst, one byte each
`define ETH_MAX_BURST 16

`endif

/* eth_dma_pkg.sv */
// Data types of the transmit DMA
// Descriptor status layout and the status/pointer word union
`include "eth_dma_consts.svh"

package eth_dma_pkg;

   typedef logic [7:0]                  byte_t;
   typedef logic [`ETH_AXI_ADDR_W-1:0]  axi_addr_t;
   typedef logic [`ETH_BUF_ADDR_W-1:0]  buf_addr_t;
   typedef logic [`ETH_BD_ADDR_W-2:0]   bd_slot_t;
   typedef logic [`ETH_BUF_ADDR_W-1:0]  frame_len_t;

   // Status word, first word of each descriptor
   typedef struct packed {
      logic [15:0] length;
      logic        ready;
      logic        irq;
      logic        wrap;
      logic        rsvd_hi;
      logic        crc_en;
      logic [10:0] rsvd_lo;
   } bd_status_t;

   // Same table word seen as status or as buffer pointer
   typedef union packed {
      bd_status_t status;
      axi_addr_t  ptr;
   } bd_word_u;

endpackage

/* bd_ctrl_if.sv */
// Handshake-free link between the transmit FSM and the descriptor tracker
`timescale 1ns/1ns

interface bd_ctrl_if;
   import eth_dma_pkg::*;

   // Strobes from the FSM
   logic       fetch_status;
   logic       fetch_ptr;
   logic       write_status;
   logic       advance;

   // Descriptor levels from the tracker
   logic       desc_ready;
   frame_len_t frame_len;
   axi_addr_t  buf_ptr;

   modport ctrl (
      output fetch_status, fetch_ptr, write_status, advance,
      input  desc_ready, frame_len, buf_ptr
   );

   modport tracker (
      input  fetch_status, fetch_ptr, write_status, advance,
      output desc_ready, frame_len, buf_ptr
   );

endinterface

/* burst_ctrl_if.sv */
// Link between the transmit FSM and the burst engine
`timescale 1ns/1ns

interface burst_ctrl_if;

   // Strobes from the FSM
   logic clear_count;
   logic issue;
   logic stream;

   // Levels and pulses from the engine
   logic fill_done;
   logic frame_done;
   logic ar_taken;
   logic burst_last;

   modport ctrl (
      output clear_count, issue, stream,
      input  fill_done, frame_done, ar_taken, burst_last
   );

   modport engine (
      input  clear_count, issue, stream,
      output fill_done, frame_done, ar_taken, burst_last
   );

endinterface

/* tx_dma_ctrl.sv */
// Transmit FSM: descriptor fetch, burst transfer, send and status writeback
`timescale 1ns/1ns

module tx_dma_ctrl (
   input  logic        clk_i,
   input  logic        arst_i,
   input  logic        tx_en_i,
   input  logic        tx_ready_i,
   bd_ctrl_if.ctrl     bd,
   burst_ctrl_if.ctrl  burst,
   output logic        send_o
);

   typedef enum logic [3:0] {
      ST_FILL,
      ST_REQ_STAT,
      ST_RD_STAT,
      ST_REQ_PTR,
      ST_RD_PTR,
      ST_ISSUE,
      ST_STREAM,
      ST_WAIT_TX,
      ST_WR_STAT
   } state_t;

   state_t state_q;
   state_t state_d;
   logic   send_q;

   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_FILL: begin
            if (burst.fill_done) state_d = ST_REQ_STAT;
         end
         ST_REQ_STAT: state_d = ST_RD_STAT;
         ST_RD_STAT: begin
            // Retry the same slot until it is ready and transmit is on
            if (bd.desc_ready && tx_en_i) state_d = ST_REQ_PTR;
            else state_d = ST_REQ_STAT;
         end
         ST_REQ_PTR: state_d = ST_RD_PTR;
         ST_RD_PTR: begin
            if (tx_ready_i) state_d = ST_ISSUE;
         end
         ST_ISSUE: begin
            if (burst.frame_done) state_d = ST_WAIT_TX;
            else if (burst.ar_taken) state_d = ST_STREAM;
         end
         ST_STREAM: begin
            if (burst.burst_last) state_d = ST_ISSUE;
         end
         ST_WAIT_TX: begin
            // Transmitter took the frame once ready drops
            if (!tx_ready_i) state_d = ST_WR_STAT;
         end
         ST_WR_STAT: state_d = ST_REQ_STAT;
         default: state_d = ST_FILL;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (arst_i) begin
         state_q <= ST_FILL;
         send_q  <= 1'b0;
      end else begin
         state_q <= state_d;
         if (state_q == ST_ISSUE && burst.frame_done) begin
            send_q <= 1'b1;
         end else if (state_q == ST_WAIT_TX && !tx_ready_i) begin
            send_q <= 1'b0;
         end
      end
   end

   // Descriptor table strobes
   assign bd.fetch_status = (state_q == ST_REQ_STAT);
   assign bd.fetch_ptr    = (state_q == ST_REQ_PTR);
   assign bd.write_status = (state_q == ST_WR_STAT);
   assign bd.advance      = (state_q == ST_WR_STAT);

   // Burst strobes, no new burst once the whole frame is in
   assign burst.clear_count = (state_q == ST_RD_PTR);
   assign burst.issue       = (state_q == ST_ISSUE) && !burst.frame_done;
   assign burst.stream      = (state_q == ST_STREAM);

   assign send_o = send_q;

endmodule

/* tx_bd_tracker.sv */
// Descriptor table port, latched status and pointer, slot counter
// and transmitter settings
`timescale 1ns/1ns
`include "eth_dma_consts.svh"

module tx_bd_tracker (
   input  logic                       clk_i,
   input  logic                       arst_i,
   bd_ctrl_if.tracker                 bd,
   output logic                       bd_en_o,
   output logic [`ETH_BD_ADDR_W-1:0]  bd_addr_o,
   output logic                       bd_wen_o,
   output eth_dma_pkg::bd_word_u      bd_wdata_o,
   input  eth_dma_pkg::bd_word_u      bd_rdata_i,
   output logic                       crc_en_o,
   output logic                       tx_irq_o,
   output eth_dma_pkg::frame_len_t    tx_nbytes_o
);
   import eth_dma_pkg::*;

   bd_slot_t   slot_q;
   logic       stat_pend;
   logic       ptr_pend;
   bd_status_t status_q;
   bd_status_t status_rd;
   axi_addr_t  ptr_q;

   // Stored copy goes back to the table with ready cleared
   always_comb begin
      status_rd       = bd_rdata_i.status;
      status_rd.ready = 1'b0;
   end

   // Status word at even address, pointer word right after it
   assign bd_addr_o = {slot_q, bd.fetch_ptr};
   assign bd_en_o   = bd.fetch_status | bd.fetch_ptr | bd.write_status;
   assign bd_wen_o  = bd.write_status;
   assign bd_wdata_o.status = status_q;
   assign tx_irq_o  = bd.write_status & status_q.irq;

   // Ready is only seen while the status word is on the read bus
   assign bd.desc_ready = stat_pend & bd_rdata_i.status.ready;
   assign bd.frame_len  = status_q.length[`ETH_BUF_ADDR_W-1:0];
   assign bd.buf_ptr    = ptr_q;

   always_ff @(posedge clk_i) begin
      if (arst_i) begin
         slot_q      <= '0;
         stat_pend   <= 1'b0;
         ptr_pend    <= 1'b0;
         crc_en_o    <= 1'b0;
         tx_nbytes_o <= '0;
      end else begin
         // Table read has one cycle of latency
         stat_pend <= bd.fetch_status;
         ptr_pend  <= bd.fetch_ptr;
         if (bd.advance) begin
            if (status_q.wrap || &slot_q) slot_q <= '0;
            else slot_q <= slot_q + 1'b1;
         end
         // Settings for the frame about to be fetched
         if (ptr_pend) begin
            crc_en_o    <= status_q.crc_en;
            tx_nbytes_o <= bd.frame_len + frame_len_t'(`ETH_PREAMBLE_LEN + 1);
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (stat_pend) status_q <= status_rd;
      if (ptr_pend) ptr_q <= bd_rdata_i.ptr;
   end

endmodule

/* tx_burst_engine.sv */
// Byte counter, AXI read address channel, byte-lane select
// and frame buffer writes including the preamble fill
`timescale 1ns/1ns
`include "eth_dma_consts.svh"

module tx_burst_engine (
   input  logic                        clk_i,
   input  logic                        arst_i,
   burst_ctrl_if.engine                burst,
   input  eth_dma_pkg::frame_len_t     frame_len_i,
   input  eth_dma_pkg::axi_addr_t      buf_ptr_i,
   // AXI read channels
   output eth_dma_pkg::axi_addr_t      axi_araddr_o,
   output logic [`ETH_AXI_LEN_W-1:0]   axi_arlen_o,
   output logic                        axi_arvalid_o,
   output logic                        axi_rready_o,
   input  logic                        axi_arready_i,
   input  logic [`ETH_AXI_DATA_W-1:0]  axi_rdata_i,
   input  logic                        axi_rvalid_i,
   input  logic                        axi_rlast_i,
   // Frame buffer write port
   output logic                        buf_wen_o,
   output eth_dma_pkg::buf_addr_t      buf_addr_o,
   output eth_dma_pkg::byte_t          buf_wdata_o
);
   import eth_dma_pkg::*;

   typedef logic [`ETH_AXI_LEN_W-1:0] axi_len_t;

   frame_len_t byte_cnt;
   frame_len_t remain;
   axi_addr_t  cur_addr;
   axi_len_t   arlen_d;
   byte_t      lane_byte;
   byte_t      fill_byte;
   logic       fill_on;
   logic       fill_done_q;
   logic       arvalid_q;
   logic       beat;

   // Next byte to move and how many are left
   assign remain   = frame_len_i - byte_cnt;
   assign cur_addr = buf_ptr_i + axi_addr_t'(byte_cnt);

   always_comb begin
      if (remain > frame_len_t'(`ETH_MAX_BURST)) arlen_d = axi_len_t'(`ETH_MAX_BURST - 1);
      else arlen_d = axi_len_t'(remain) - 1'b1;
   end

   // Byte lane of a single-byte beat
   assign lane_byte = axi_rdata_i[cur_addr[1:0]*8 +: 8];
   assign fill_byte = (byte_cnt == frame_len_t'(`ETH_PREAMBLE_LEN)) ?
                      `ETH_SFD_BYTE : `ETH_PREAMBLE_BYTE;

   assign beat         = burst.stream & axi_rvalid_i;
   assign axi_rready_o = burst.stream & axi_rvalid_i;

   // Preamble at the bottom, payload right after the SFD
   assign buf_wen_o   = fill_on | beat;
   assign buf_addr_o  = fill_on ? buf_addr_t'(byte_cnt) :
                        buf_addr_t'(byte_cnt) + buf_addr_t'(`ETH_PREAMBLE_LEN + 1);
   assign buf_wdata_o = fill_on ? fill_byte : lane_byte;

   assign burst.fill_done  = fill_done_q;
   assign burst.frame_done = (byte_cnt == frame_len_i);
   assign burst.ar_taken   = arvalid_q & axi_arready_i;
   assign burst.burst_last = beat & axi_rlast_i;

   assign axi_arvalid_o = arvalid_q;

   always_ff @(posedge clk_i) begin
      if (arst_i) begin
         byte_cnt    <= '0;
         fill_on     <= 1'b0;
         fill_done_q <= 1'b0;
         arvalid_q   <= 1'b0;
      end else begin
         if (!fill_on && !fill_done_q) fill_on <= 1'b1;

         if (burst.clear_count) begin
            byte_cnt <= '0;
         end else if (fill_on) begin
            if (byte_cnt == frame_len_t'(`ETH_PREAMBLE_LEN)) begin
               byte_cnt    <= '0;
               fill_on     <= 1'b0;
               fill_done_q <= 1'b1;
            end else begin
               byte_cnt <= byte_cnt + 1'b1;
            end
         end else if (beat) begin
            byte_cnt <= byte_cnt + 1'b1;
         end

         // Address stays valid until the slave takes it
         if (arvalid_q && axi_arready_i) arvalid_q <= 1'b0;
         else if (burst.issue && !arvalid_q) arvalid_q <= 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (burst.issue && !arvalid_q) begin
         axi_araddr_o <= cur_addr;
         axi_arlen_o  <= arlen_d;
      end
   end

endmodule

/* eth_tx_dma.sv */
// Top level of the Ethernet transmit DMA
`timescale 1ns/1ns
`include "eth_dma_consts.svh"

module eth_tx_dma (
   input  logic                        clk_i,
   input  logic                        arst_i,
   input  logic                        tx_en_i,
   // Transmitter
   input  logic                        tx_ready_i,
   output logic                        send_o,
   output logic                        crc_en_o,
   output eth_dma_pkg::frame_len_t     tx_nbytes_o,
   output logic                        tx_irq_o,
   // Descriptor table
   output logic                        bd_en_o,
   output logic [`ETH_BD_ADDR_W-1:0]   bd_addr_o,
   output logic                        bd_wen_o,
   output eth_dma_pkg::bd_word_u       bd_wdata_o,
   input  eth_dma_pkg::bd_word_u       bd_rdata_i,
   // External memory read
   output eth_dma_pkg::axi_addr_t      axi_araddr_o,
   output logic [`ETH_AXI_LEN_W-1:0]   axi_arlen_o,
   output logic                        axi_arvalid_o,
   input  logic                        axi_arready_i,
   input  logic [`ETH_AXI_DATA_W-1:0]  axi_rdata_i,
   input  logic                        axi_rvalid_i,
   input  logic                        axi_rlast_i,
   output logic                        axi_rready_o,
   // Frame buffer
   output logic                        buf_wen_o,
   output eth_dma_pkg::buf_addr_t      buf_addr_o,
   output eth_dma_pkg::byte_t          buf_wdata_o
);

   bd_ctrl_if    bd_if ();
   burst_ctrl_if burst_if ();

   tx_dma_ctrl ctrl0 (
      .clk_i     (clk_i),
      .arst_i    (arst_i),
      .tx_en_i   (tx_en_i),
      .tx_ready_i(tx_ready_i),
      .bd        (bd_if.ctrl),
      .burst     (burst_if.ctrl),
      .send_o    (send_o)
   );

   tx_bd_tracker tracker0 (
      .clk_i      (clk_i),
      .arst_i     (arst_i),
      .bd         (bd_if.tracker),
      .bd_en_o    (bd_en_o),
      .bd_addr_o  (bd_addr_o),
      .bd_wen_o   (bd_wen_o),
      .bd_wdata_o (bd_wdata_o),
      .bd_rdata_i (bd_rdata_i),
      .crc_en_o   (crc_en_o),
      .tx_irq_o   (tx_irq_o),
      .tx_nbytes_o(tx_nbytes_o)
   );

   tx_burst_engine engine0 (
      .clk_i        (clk_i),
      .arst_i       (arst_i),
      .burst        (burst_if.engine),
      .frame_len_i  (bd_if.frame_len),
      .buf_ptr_i    (bd_if.buf_ptr),
      .axi_araddr_o (axi_araddr_o),
      .axi_arlen_o  (axi_arlen_o),
      .axi_arvalid_o(axi_arvalid_o),
      .axi_rready_o (axi_rready_o),
      .axi_arready_i(axi_arready_i),
      .axi_rdata_i  (axi_rdata_i),
      .axi_rvalid_i (axi_rvalid_i),
      .axi_rlast_i  (axi_rlast_i),
      .buf_wen_o    (buf_wen_o),
      .buf_addr_o   (buf_addr_o),
      .buf_wdata_o  (buf_wdata_o)
   );

endmodule

/* tb_clk_gen.sv */
// Testbench clock and synchronous reset source
`timescale 1ns/1ns

module tb_clk_gen #(
   parameter int PERIOD_NS    = 8,
   parameter int RESET_CYCLES = 16
) (
   output logic clk_o,
   output logic arst_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2) clk_o = ~clk_o;
   end

   // Reset released on a falling edge, like every other input
   initial begin
      arst_o = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk_o);
      @(negedge clk_o);
      arst_o = 1'b0;
   end

endmodule

/* eth_tx_dma_tb.sv */
// Testbench for the Ethernet transmit DMA with descriptor table, AXI memory,
// frame buffer and transmitter models, vector reader and watchdog
`timescale 1ns/1ns
`include "eth_dma_consts.svh"

module eth_tx_dma_tb;
   import eth_dma_pkg::*;

   localparam int MEM_BYTES = 4096;
   localparam int MAX_VEC   = 64;

   logic clk, arst;
   logic tx_en_i, tx_ready_i, send_o, crc_en_o, tx_irq_o;
   frame_len_t tx_nbytes_o;
   logic bd_en_o, bd_wen_o;
   logic [`ETH_BD_ADDR_W-1:0] bd_addr_o;
   bd_word_u bd_wdata_o, bd_rdata_i;
   axi_addr_t axi_araddr_o;
   logic [`ETH_AXI_LEN_W-1:0] axi_arlen_o;
   logic axi_arvalid_o, axi_arready_i, axi_rvalid_i, axi_rlast_i, axi_rready_o;
   logic [`ETH_AXI_DATA_W-1:0] axi_rdata_i;
   logic buf_wen_o;
   buf_addr_t buf_addr_o;
   byte_t buf_wdata_o;

   bd_word_u bd_mem [0:255];
   byte_t ext_mem [0:MEM_BYTES-1];
   byte_t fbuf [0:2047];
   integer seed;

   int vec_slot [MAX_VEC];
   int vec_len [MAX_VEC];
   int vec_flags [MAX_VEC];
   int vec_seed [MAX_VEC];
   axi_addr_t vec_ptr [MAX_VEC];
   int nvec, max_len;

   // Descriptor in flight and model state
   bd_status_t cur_stat;
   axi_addr_t cur_ptr, r_addr;
   bd_slot_t exp_slot;
   logic axi_allowed, send_seen, frame_seen, ar_seen, vec_loaded;
   int moved, beats, wb_count, fetch_count, tx_hold, ar_delay, r_left;

   tb_clk_gen #(.PERIOD_NS(8), .RESET_CYCLES(16)) clk_gen0 (.clk_o(clk), .arst_o(arst));

   eth_tx_dma dut0 (.clk_i(clk), .arst_i(arst), .*);

   task automatic abort_run(input string line);
      $display("%s", line);
      $display("SOME TESTS FAILED");
      $fatal(1, "stopping the run");
   endtask

   task automatic check_byte(input byte_t act, input byte_t exp, input string what);
      if (act !== exp)
         abort_run($sformatf("MISMATCH at %0t ns: %s is %h, expected %h",
                             $time, what, act, exp));
   endtask

   task automatic check_bd_word(input bd_word_u act, input bd_word_u exp, input string what);
      if (act !== exp)
         abort_run($sformatf("MISMATCH at %0t ns: %s is %h, expected %h",
                             $time, what, act, exp));
   endtask

   task automatic check_nbytes(input frame_len_t act, input frame_len_t exp, input string what);
      if (act !== exp)
         abort_run($sformatf("MISMATCH at %0t ns: %s is %0d, expected %0d",
                             $time, what, act, exp));
   endtask

   task automatic check_addr(input axi_addr_t act, input axi_addr_t exp, input string what);
      if (act !== exp)
         abort_run($sformatf("MISMATCH at %0t ns: %s is %h, expected %h",
                             $time, what, act, exp));
   endtask

   task automatic check_flag(input logic act, input logic exp, input string what);
      if (act !== exp)
         abort_run($sformatf("MISMATCH at %0t ns: %s is %b, expected %b",
                             $time, what, act, exp));
   endtask

   // One descriptor per line as slot, length, hex pointer, irq, wrap, crc_en and seed
   // Lines starting with # are comments
   task automatic load_vectors();
      int fd, n, s, l, ir, wr, cr, ms;
      logic [31:0] p;
      string line;
      fd = $fopen("tx_dma_vectors.txt", "r");
      if (fd == 0) abort_run("Could not open tx_dma_vectors.txt");
      while (!$feof(fd) && nvec < MAX_VEC) begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() > 1 && line.getc(0) != "#") begin
            n = $sscanf(line, "%d %d %h %d %d %d %d", s, l, p, ir, wr, cr, ms);
            if (n != 7) abort_run("Malformed line in tx_dma_vectors.txt");
            vec_slot[nvec]  = s;
            vec_len[nvec]   = l;
            vec_ptr[nvec]   = p;
            vec_flags[nvec] = ir * 4 + wr * 2 + cr;
            vec_seed[nvec]  = ms;
            if (l > max_len) max_len = l;
            nvec++;
         end
      end
      $fclose(fd);
      if (nvec == 0) abort_run("No vectors found in tx_dma_vectors.txt");
      vec_loaded = 1'b1;
   endtask

   task automatic check_frame();
      int a;
      for (a = 0; a < int'(cur_stat.length); a++)
         check_byte(fbuf[8 + a], ext_mem[(cur_ptr + a) % MEM_BYTES],
                    $sformatf("frame byte %0d", a));
      check_nbytes(frame_len_t'(beats), frame_len_t'(cur_stat.length), "beats moved");
      check_nbytes(tx_nbytes_o, frame_len_t'(cur_stat.length + 8), "tx_nbytes_o");
      check_flag(crc_en_o, cur_stat.crc_en, "crc_en_o");
   endtask

   task automatic serve_table();
      bd_word_u exp_wb;
      if (bd_en_o && bd_wen_o) begin
         exp_wb.status       = cur_stat;
         exp_wb.status.ready = 1'b0;
         check_flag(bd_addr_o == {exp_slot, 1'b0}, 1'b1, "write-back address match");
         check_bd_word(bd_wdata_o, exp_wb, "status write-back");
         check_flag(tx_irq_o, cur_stat.irq, "tx_irq_o at write-back");
         check_flag(frame_seen, 1'b1, "frame sent before write-back");
         bd_mem[bd_addr_o] = bd_wdata_o;
         frame_seen  = 1'b0;
         axi_allowed = 1'b0;
         // Wrap bit or last slot returns to slot 0
         exp_slot = (cur_stat.wrap || &exp_slot) ? '0 : exp_slot + 1'b1;
         wb_count++;
      end else begin
         check_flag(tx_irq_o, 1'b0, "tx_irq_o outside write-back");
         if (bd_en_o) begin
            if (!bd_addr_o[0]) begin
               check_flag(bd_addr_o[`ETH_BD_ADDR_W-1:1] == exp_slot, 1'b1,
                          "fetched slot match");
               fetch_count++;
            end
            bd_rdata_i = bd_mem[bd_addr_o];
         end
      end
   endtask

   task automatic serve_axi();
      int rem;
      byte_t exp_len;
      axi_addr_t base;
      if (axi_arready_i) begin
         // Address taken on the last rising edge
         axi_arready_i = 1'b0;
         r_addr = axi_araddr_o;
         r_left = int'(axi_arlen_o) + 1;
         moved  = moved + r_left;
         ar_seen = 1'b0;
      end else if (axi_arvalid_o) begin
         if (!ar_seen) begin
            rem = int'(cur_stat.length) - moved;
            exp_len = byte_t'((rem > `ETH_MAX_BURST) ? `ETH_MAX_BURST - 1 : rem - 1);
            check_flag(axi_allowed, 1'b1, "read burst allowed");
            check_addr(axi_araddr_o, cur_ptr + axi_addr_t'(moved), "burst address");
            check_byte(axi_arlen_o, exp_len, "burst length");
            ar_seen  = 1'b1;
            ar_delay = $random(seed) & 3;
         end
         if (ar_delay == 0) axi_arready_i = 1'b1;
         else ar_delay--;
      end
      if (axi_rvalid_i) begin
         r_addr = r_addr + 1;
         r_left--;
         beats++;
         axi_rvalid_i = 1'b0;
         axi_rlast_i  = 1'b0;
      end
      // Random gaps in rvalid
      if (r_left > 0 && ($random(seed) & 3) != 0) begin
         base = (r_addr & ~axi_addr_t'(3)) % MEM_BYTES;
         axi_rdata_i  = {ext_mem[base + 3], ext_mem[base + 2],
                         ext_mem[base + 1], ext_mem[base]};
         axi_rvalid_i = 1'b1;
         axi_rlast_i  = (r_left == 1);
      end
   endtask

   // Transmitter drops ready a few cycles after send and raises it once send falls
   task automatic serve_transmitter();
      if (send_o && !send_seen) begin
         send_seen  = 1'b1;
         frame_seen = 1'b1;
         check_frame();
         tx_hold = $random(seed) & 3;
      end else if (send_seen && send_o) begin
         if (tx_hold == 0) tx_ready_i = 1'b0;
         else tx_hold--;
      end else if (send_seen && !send_o) begin
         tx_ready_i = 1'b1;
         send_seen  = 1'b0;
      end
   endtask

   // Buffer writes and beat acceptance happen on the rising edge
   always @(posedge clk) begin
      if (!arst) begin
         if (buf_wen_o) fbuf[buf_addr_o] = buf_wdata_o;
         check_flag(axi_rready_o, axi_rvalid_i, "axi_rready_o");
      end
   end

   always @(negedge clk) begin
      if (!arst) begin
         serve_table();
         serve_axi();
         serve_transmitter();
      end
   end

   task automatic run_descriptor(input int i);
      int a;
      if (vec_slot[i] != int'(exp_slot))
         abort_run("Vector slot order does not follow the wrap rule");
      seed = seed + vec_seed[i];
      for (a = 0; a < MEM_BYTES; a++) ext_mem[a] = byte_t'($random(seed));
      for (a = 0; a < vec_len[i]; a++) fbuf[8 + a] = ~ext_mem[(vec_ptr[i] + a) % MEM_BYTES];
      cur_stat        = '0;
      cur_stat.length = 16'(vec_len[i]);
      cur_stat.ready  = 1'b1;
      cur_stat.irq    = vec_flags[i][2];
      cur_stat.wrap   = vec_flags[i][1];
      cur_stat.crc_en = vec_flags[i][0];
      cur_ptr = vec_ptr[i];
      moved   = 0;
      beats   = 0;
      // Slot held not ready first and made ready while transmit is off
      tx_en_i = 1'b1;
      repeat (12) @(negedge clk);
      tx_en_i = 1'b0;
      bd_mem[{exp_slot, 1'b1}].ptr    = cur_ptr;
      bd_mem[{exp_slot, 1'b0}].status = cur_stat;
      repeat (12) @(negedge clk);
      axi_allowed = 1'b1;
      tx_en_i     = 1'b1;
      while (wb_count == i) @(negedge clk);
   endtask

   initial begin : watchdog
      int limit;
      wait (vec_loaded);
      limit = nvec * (8 * max_len + 200);
      repeat (limit) @(posedge clk);
      abort_run($sformatf("Timeout: frames not finished after %0d cycles", limit));
   end

   initial begin : main_flow
      int i;
      tx_en_i = 1'b0;
      tx_ready_i = 1'b1;
      bd_rdata_i = '0;
      axi_arready_i = 1'b0;
      axi_rdata_i = '0;
      axi_rvalid_i = 1'b0;
      axi_rlast_i = 1'b0;
      seed = 53997;
      {axi_allowed, send_seen, frame_seen, ar_seen, vec_loaded} = '0;
      {nvec, max_len, moved, beats, wb_count, fetch_count, tx_hold, ar_delay, r_left} = '0;
      exp_slot = '0;
      for (i = 0; i < 256; i++) bd_mem[i] = '0;
      load_vectors();
      while (fetch_count == 0) @(negedge clk);
      for (i = 0; i < `ETH_PREAMBLE_LEN; i++)
         check_byte(fbuf[i], `ETH_PREAMBLE_BYTE, $sformatf("preamble byte %0d", i));
      check_byte(fbuf[`ETH_PREAMBLE_LEN], `ETH_SFD_BYTE, "start-of-frame delimiter");
      for (i = 0; i < nvec; i++) run_descriptor(i);
      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

/* tx_dma_vectors.txt */
# slot length pointer(hex) irq wrap crc_en mem_seed
# slots must follow the wrap rule starting from slot 0
0 1 0100 1 0 1 1
1 16 0203 0 0 0 2
2 17 0311 1 1 1 3
0 33 0402 0 0 1 4
1 64 0500 1 0 0 5
2 5 0627 0 0 1 6
3 100 0701 1 1 0 7
0 15 0803 0 0 1 8
1 31 0910 1 0 1 9
2 48 0a01 0 1 0 10
0 2 0b02 1 0 0 11
1 7 0c03 0 0 1 12

/* filelist.f */
+incdir+.
eth_dma_pkg.sv
bd_ctrl_if.sv
burst_ctrl_if.sv
tx_dma_ctrl.sv
tx_bd_tracker.sv
tx_burst_engine.sv
eth_tx_dma.sv
tb_clk_gen.sv
eth_tx_dma_tb.sv

/* Makefile */
SIM      := verilator
TOP      := eth_tx_dma_tb
FILELIST := filelist.f
FLAGS    := --timing -Wno-fatal
OBJ_DIR  := obj_dir

.PHONY: lint sim clean

lint:
	$(SIM) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(SIM) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
